//--- compile.f
hw/sniffer_pkg.sv
hw/sniffer_ctrl_slv.sv
hw/packet_capture.sv
hw/capture_buffer.sv
hw/packet_sniffer_top.sv
testbench/sniffer_ctrl_checker.sv
testbench/sniffer_monitor.sv
testbench/packet_sniffer_tb.sv

//--- hw/capture_buffer.sv
// Capture buffer: fixed-priority arbiter in front of a single-port synchronous RAM
`timescale 1ns/1ps

module capture_buffer (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  // Write port from the capture engine, always accepted
  input  logic                                  cap_req,
  input  logic [sniffer_pkg::BUF_ADDR_BITS-1:0] cap_addr,
  input  logic [63:0]                           cap_wdata,
  // Read port from the register slave
  input  logic                                  rd_req,
  input  logic [sniffer_pkg::BUF_ADDR_BITS-1:0] rd_addr,
  output logic                                  rd_gnt,
  output logic [63:0]                           rd_data,
  output logic                                  rd_valid
);

  import sniffer_pkg::*;

  logic [63:0] mem [BUF_DEPTH];
  logic ram_en;
  logic [BUF_ADDR_BITS-1:0] ram_addr;

  // --------------------------------------------------------------------------
  // Arbiter, capture engine first
  // --------------------------------------------------------------------------
  assign rd_gnt = rd_req && !cap_req;
  assign ram_en = cap_req || rd_gnt;
  assign ram_addr = cap_req ? cap_addr : rd_addr;

  // --------------------------------------------------------------------------
  // Single-port RAM, one cycle read latency
  // --------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (ram_en) begin
      if (cap_req) begin
        mem[ram_addr] <= cap_wdata;
      end else begin
        rd_data <= mem[ram_addr];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_gnt;
    end
  end

endmodule

//--- hw/packet_capture.sv
// Capture engine: state machine, first-beat filter, byte count, timer and buffer writes
`timescale 1ns/1ps

module packet_capture (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  logic                                  capture_en,
  input  logic [63:0]                           filter,
  // Packet stream, no back-pressure
  input  logic                                  pkt_valid,
  input  logic [63:0]                           pkt_data,
  input  logic                                  pkt_last,
  // Status
  output sniffer_pkg::capture_state_t           state,
  output logic [31:0]                           size,
  output logic [63:0]                           timer,
  // Buffer write port
  output logic                                  cap_req,
  output logic [sniffer_pkg::BUF_ADDR_BITS-1:0] cap_addr,
  output logic [63:0]                           cap_wdata
);

  import sniffer_pkg::*;

  logic in_pkt;
  logic first_beat;
  logic match;
  logic arm;
  logic buf_full;
  logic store;
  // One bit wider than the buffer address so a full buffer is visible
  logic [BUF_ADDR_BITS:0] wr_ptr;

  // Start of packet tracking, independent of the capture state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      in_pkt <= 1'b0;
    end else if (pkt_valid) begin
      in_pkt <= !pkt_last;
    end
  end

  assign first_beat = pkt_valid && !in_pkt;

  // Mask in the low half of filter, match value in the high half
  assign match = (pkt_data[31:0] & filter[31:0]) == (filter[63:32] & filter[31:0]);

  assign arm = capture_en && (state == IDLE);
  assign buf_full = (wr_ptr == BUF_DEPTH);

  // Beat that belongs to a packet being stored
  always_comb begin
    case (state)
      ARMED:   store = first_beat && match;
      CAPTURE: store = pkt_valid;
      default: store = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
      wr_ptr <= '0;
      cap_req <= 1'b0;
    end else begin
      cap_req <= 1'b0;
      if (!capture_en) begin
        state <= IDLE;
      end else if (arm) begin
        state <= ARMED;
        wr_ptr <= '0;
      end else if (store) begin
        if (buf_full) begin
          // Rest of the packet and all later ones are dropped
          state <= DONE;
        end else begin
          cap_req <= 1'b1;
          wr_ptr <= wr_ptr + 1'b1;
          state <= pkt_last ? ARMED : CAPTURE;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (store && !buf_full) begin
      cap_addr <= wr_ptr[BUF_ADDR_BITS-1:0];
      cap_wdata <= pkt_data;
    end
  end

  // --------------------------------------------------------------------------
  // Byte count and timer
  // --------------------------------------------------------------------------
  // size moves on the edge that writes the beat into the buffer
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      size <= '0;
      timer <= '0;
    end else if (arm) begin
      size <= '0;
      timer <= '0;
    end else begin
      if (cap_req) begin
        size <= size + 32'd8;
      end
      if (state == ARMED || state == CAPTURE) begin
        timer <= timer + 64'd1;
      end
    end
  end

endmodule

//--- hw/packet_sniffer_top.sv
// Packet sniffer top level: register slave, capture engine and capture buffer
`timescale 1ns/1ps

module packet_sniffer_top (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  // AXI4-Lite control
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [sniffer_pkg::AXIL_ADDR_BITS-1:0] awaddr,
  input  logic                                   wvalid,
  output logic                                   wready,
  input  logic [sniffer_pkg::AXIL_DATA_BITS-1:0] wdata,
  input  logic [sniffer_pkg::AXIL_STRB_BITS-1:0] wstrb,
  output logic                                   bvalid,
  input  logic                                   bready,
  output logic [1:0]                             bresp,
  input  logic                                   arvalid,
  output logic                                   arready,
  input  logic [sniffer_pkg::AXIL_ADDR_BITS-1:0] araddr,
  output logic                                   rvalid,
  input  logic                                   rready,
  output logic [sniffer_pkg::AXIL_DATA_BITS-1:0] rdata,
  output logic [1:0]                             rresp,
  // Packet stream
  input  logic                                   pkt_valid,
  input  logic [63:0]                            pkt_data,
  input  logic                                   pkt_last,
  // Host descriptor
  output logic                                   host_valid,
  output logic [sniffer_pkg::VADDR_BITS-1:0]     host_vaddr,
  output logic [sniffer_pkg::LEN_BITS-1:0]       host_len,
  output logic [sniffer_pkg::PID_BITS-1:0]       host_pid,
  output logic [sniffer_pkg::DEST_BITS-1:0]      host_dest
);

  import sniffer_pkg::*;

  // Slave to capture engine
  logic capture_en;
  logic [63:0] filter;
  capture_state_t state;
  logic [31:0] size;
  logic [63:0] timer;

  // Buffer write and read ports
  logic cap_req;
  logic [BUF_ADDR_BITS-1:0] cap_addr;
  logic [63:0] cap_wdata;
  logic rd_req;
  logic [BUF_ADDR_BITS-1:0] rd_addr;
  logic rd_gnt;
  logic [63:0] rd_data;
  logic rd_valid;

  // All ports share their names with the nets above
  sniffer_ctrl_slv sniffer_ctrl_slv_inst (.*);

  packet_capture packet_capture_inst (.*);

  capture_buffer capture_buffer_inst (.*);

endmodule

//--- hw/sniffer_ctrl_slv.sv
// AXI4-Lite register slave with sniffer register map, host descriptor and buffer read window
`timescale 1ns/1ps

module sniffer_ctrl_slv (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  // AXI4-Lite write channels
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [sniffer_pkg::AXIL_ADDR_BITS-1:0] awaddr,
  input  logic                                   wvalid,
  output logic                                   wready,
  input  logic [sniffer_pkg::AXIL_DATA_BITS-1:0] wdata,
  input  logic [sniffer_pkg::AXIL_STRB_BITS-1:0] wstrb,
  output logic                                   bvalid,
  input  logic                                   bready,
  output logic [1:0]                             bresp,
  // AXI4-Lite read channels
  input  logic                                   arvalid,
  output logic                                   arready,
  input  logic [sniffer_pkg::AXIL_ADDR_BITS-1:0] araddr,
  output logic                                   rvalid,
  input  logic                                   rready,
  output logic [sniffer_pkg::AXIL_DATA_BITS-1:0] rdata,
  output logic [1:0]                             rresp,
  // Capture engine
  output logic                                   capture_en,
  output logic [63:0]                            filter,
  input  sniffer_pkg::capture_state_t            state,
  input  logic [31:0]                            size,
  input  logic [63:0]                            timer,
  // Host descriptor
  output logic                                   host_valid,
  output logic [sniffer_pkg::VADDR_BITS-1:0]     host_vaddr,
  output logic [sniffer_pkg::LEN_BITS-1:0]       host_len,
  output logic [sniffer_pkg::PID_BITS-1:0]       host_pid,
  output logic [sniffer_pkg::DEST_BITS-1:0]      host_dest,
  // Capture buffer read port
  output logic                                   rd_req,
  output logic [sniffer_pkg::BUF_ADDR_BITS-1:0]  rd_addr,
  input  logic                                   rd_gnt,
  input  logic [63:0]                            rd_data,
  input  logic                                   rd_valid
);

  import sniffer_pkg::*;

  logic [AXIL_ADDR_BITS-1:0] axi_awaddr;
  logic [AXIL_ADDR_BITS-1:0] axi_araddr;
  logic axi_awready;
  logic axi_wready;
  logic axi_arready;
  logic axi_bvalid;
  logic axi_rvalid;
  logic [AXIL_DATA_BITS-1:0] axi_rdata;
  logic aw_en;
  logic aw_accept;
  logic ar_accept;
  logic wr_done;
  logic rd_busy;
  logic slv_reg_wren;
  logic slv_reg_rden;
  logic buf_rd;
  logic reg_writable;
  logic [REG_IDX_BITS-1:0] wr_idx;
  logic [REG_IDX_BITS-1:0] rd_idx;
  logic [AXIL_DATA_BITS-1:0] rd_mux;

  logic [N_REGS-1:0][AXIL_DATA_BITS-1:0] slv_reg;

  assign wr_idx = axi_awaddr[ADDR_LSB +: REG_IDX_BITS];
  assign rd_idx = axi_araddr[ADDR_LSB +: REG_IDX_BITS];

  // --------------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------------
  assign slv_reg_wren = axi_awready && awvalid && axi_wready && wvalid;

  always_comb begin
    case (wr_idx)
      CTRL_0, CTRL_1, FILTER, VADDR, LEN, PID, DEST, BUF_ADDR: reg_writable = 1'b1;
      default: reg_writable = 1'b0;
    endcase
  end

  // Byte merge under wstrb; status slots are never written
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      slv_reg <= '0;
    end else if (slv_reg_wren && reg_writable) begin
      for (int i = 0; i < AXIL_STRB_BITS; i++) begin
        if (wstrb[i]) begin
          slv_reg[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // Read values, truncated to the width of each field
  always_comb begin
    rd_mux = '0;
    case (rd_idx)
      CTRL_0:   rd_mux[0] = slv_reg[CTRL_0][0];
      CTRL_1:   rd_mux[0] = slv_reg[CTRL_1][0];
      FILTER:   rd_mux = slv_reg[FILTER];
      STATE:    rd_mux[1:0] = state;
      SIZE:     rd_mux[31:0] = size;
      TIMER:    rd_mux = timer;
      VADDR:    rd_mux[VADDR_BITS-1:0] = slv_reg[VADDR][VADDR_BITS-1:0];
      LEN:      rd_mux[LEN_BITS-1:0] = slv_reg[LEN][LEN_BITS-1:0];
      PID:      rd_mux[PID_BITS-1:0] = slv_reg[PID][PID_BITS-1:0];
      DEST:     rd_mux[DEST_BITS-1:0] = slv_reg[DEST][DEST_BITS-1:0];
      BUF_ADDR: rd_mux[BUF_ADDR_BITS-1:0] = slv_reg[BUF_ADDR][BUF_ADDR_BITS-1:0];
      default:  rd_mux = '0;
    endcase
  end

  assign capture_en = slv_reg[CTRL_0][0];
  assign filter = slv_reg[FILTER];
  assign host_valid = slv_reg[CTRL_1][0];
  assign host_vaddr = slv_reg[VADDR][VADDR_BITS-1:0];
  assign host_len = slv_reg[LEN][LEN_BITS-1:0];
  assign host_pid = slv_reg[PID][PID_BITS-1:0];
  assign host_dest = slv_reg[DEST][DEST_BITS-1:0];
  assign rd_addr = slv_reg[BUF_ADDR][BUF_ADDR_BITS-1:0];

  // --------------------------------------------------------------------------
  // Write handshake
  // --------------------------------------------------------------------------
  assign aw_accept = !axi_awready && awvalid && wvalid && aw_en;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      axi_awready <= 1'b0;
      axi_wready <= 1'b0;
      aw_en <= 1'b1;
      wr_done <= 1'b0;
      axi_bvalid <= 1'b0;
    end else begin
      axi_awready <= aw_accept;
      axi_wready <= aw_accept;
      wr_done <= slv_reg_wren;
      if (aw_accept) begin
        aw_en <= 1'b0;
      end else if (bready && axi_bvalid) begin
        aw_en <= 1'b1;
      end
      // Response one cycle after the register update
      if (wr_done) begin
        axi_bvalid <= 1'b1;
      end else if (bready && axi_bvalid) begin
        axi_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_accept) begin
      axi_awaddr <= awaddr;
    end
  end

  // --------------------------------------------------------------------------
  // Read handshake and buffer read sequencer
  // --------------------------------------------------------------------------
  assign ar_accept = !axi_arready && arvalid && !axi_rvalid && !rd_busy;
  assign slv_reg_rden = axi_arready && arvalid && !axi_rvalid;
  assign buf_rd = slv_reg_rden && (rd_idx == BUF_DATA);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      axi_arready <= 1'b0;
      axi_rvalid <= 1'b0;
      rd_req <= 1'b0;
      rd_busy <= 1'b0;
    end else begin
      axi_arready <= ar_accept;
      if ((slv_reg_rden && !buf_rd) || rd_valid) begin
        axi_rvalid <= 1'b1;
      end else if (axi_rvalid && rready) begin
        axi_rvalid <= 1'b0;
      end
      // BUF_DATA waits here until the buffer returns the word
      if (buf_rd) begin
        rd_req <= 1'b1;
      end else if (rd_gnt) begin
        rd_req <= 1'b0;
      end
      if (buf_rd) begin
        rd_busy <= 1'b1;
      end else if (rd_valid) begin
        rd_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_accept) begin
      axi_araddr <= araddr;
    end
    if (slv_reg_rden && !buf_rd) begin
      axi_rdata <= rd_mux;
    end else if (rd_valid) begin
      axi_rdata <= rd_data;
    end
  end

  assign awready = axi_awready;
  assign wready = axi_wready;
  assign bvalid = axi_bvalid;
  assign bresp = 2'b00;
  assign arready = axi_arready;
  assign rvalid = axi_rvalid;
  assign rdata = axi_rdata;
  assign rresp = 2'b00;

endmodule

//--- hw/sniffer_pkg.sv
// Sniffer widths, register map indices, capture buffer size and capture state type

package sniffer_pkg;

  // --------------------------------------------------------------------------
  // AXI4-Lite control bus
  // --------------------------------------------------------------------------
  localparam int AXIL_DATA_BITS = 64;
  localparam int AXIL_ADDR_BITS = 7;
  localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;
  // Byte offset inside one register, then the register index above it
  localparam int ADDR_LSB = $clog2(AXIL_STRB_BITS);
  localparam int REG_IDX_BITS = AXIL_ADDR_BITS - ADDR_LSB;

  localparam int N_REGS = 12;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------
  localparam int CTRL_0 = 0;    // Capture enable, bit 0
  localparam int CTRL_1 = 1;    // Host descriptor valid, bit 0
  localparam int FILTER = 2;    // Mask low, match value high
  localparam int STATE = 3;
  localparam int SIZE = 4;
  localparam int TIMER = 5;
  localparam int VADDR = 6;
  localparam int LEN = 7;
  localparam int PID = 8;
  localparam int DEST = 9;
  localparam int BUF_ADDR = 10;
  localparam int BUF_DATA = 11;  // Read window into the capture buffer

  // Host descriptor fields
  localparam int VADDR_BITS = 48;
  localparam int LEN_BITS = 28;
  localparam int PID_BITS = 6;
  localparam int DEST_BITS = 4;

  // Capture buffer, in 64-bit words
  localparam int BUF_DEPTH = 256;
  localparam int BUF_ADDR_BITS = 8;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ARMED = 2'd1,
    CAPTURE = 2'd2,
    DONE = 2'd3
  } capture_state_t;

endpackage

//--- testbench/packet_sniffer_tb.sv
// Testbench top with clock, reset, stimulus table, LCG, drivers, timeout and summary
`timescale 1ns/1ps

module packet_sniffer_tb;

  import sniffer_pkg::*;

  typedef enum {K_WR, K_RD, K_RD_GT, K_RD_BUF, K_RD_BUF_PKT, K_PKT, K_HOST} kind_t;
  typedef struct {
    kind_t kind;
    int idx;
    logic [63:0] data;
    logic [7:0] strb;
    int beats;
    bit match;
    logic [127:0] exp;
  } entry_t;

  logic aclk, aresetn;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [AXIL_ADDR_BITS-1:0] awaddr, araddr;
  logic [63:0] wdata, rdata, pkt_data;
  logic [7:0] wstrb;
  logic [1:0] bresp, rresp;
  logic pkt_valid, pkt_last, host_valid;
  logic [VADDR_BITS-1:0] host_vaddr;
  logic [LEN_BITS-1:0] host_len;
  logic [PID_BITS-1:0] host_pid;
  logic [DEST_BITS-1:0] host_dest;
  logic [127:0] exp_data;
  logic exp_gt, host_chk;
  int test_id, n_pass, n_fail, cycles, limit;

  entry_t table_q[$];
  logic [63:0] model [BUF_DEPTH];
  int model_ptr;
  bit cap_on, cap_done;
  logic [7:0] buf_addr;
  logic [31:0] lcg_state = 32'h54691baa;

  packet_sniffer_top packet_sniffer_top_inst (.*);
  sniffer_monitor monitor_inst (.*);
  bind sniffer_ctrl_slv sniffer_ctrl_checker ctrl_checker_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add(kind_t k, int idx, logic [63:0] d, logic [7:0] s, int beats, bit m,
                     logic [127:0] e);
    entry_t t;
    t = '{k, idx, d, s, beats, m, e};
    table_q.push_back(t);
  endtask

  task automatic axi_write(int id, int idx, logic [63:0] d, logic [7:0] s);
    @(posedge aclk);
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    awaddr <= AXIL_ADDR_BITS'(idx * 8);
    wdata <= d;
    wstrb <= s;
    test_id <= id;
    do @(posedge aclk); while (!awready);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    // Response is held one cycle before bready takes it
    do @(posedge aclk); while (!bvalid);
    bready <= 1'b1;
    @(posedge aclk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(int id, int idx, logic [127:0] e, bit gt);
    @(posedge aclk);
    arvalid <= 1'b1;
    araddr <= AXIL_ADDR_BITS'(idx * 8);
    exp_data <= e;
    exp_gt <= gt;
    test_id <= id;
    do @(posedge aclk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge aclk); while (!rvalid);
    rready <= 1'b1;
    @(posedge aclk);
    rready <= 1'b0;
  endtask

  // Stream one packet; the model stores beats the way an armed engine would
  task automatic send_packet(int beats, bit m);
    logic [63:0] d;
    for (int b = 0; b < beats; b++) begin
      d = {lcg_next(), lcg_next()};
      if (b == 0) begin
        d[7:0] = m ? 8'hA5 : 8'h5A;
      end
      @(posedge aclk);
      pkt_valid <= 1'b1;
      pkt_data <= d;
      pkt_last <= (b == beats - 1);
      if (cap_on && m && !cap_done) begin
        if (model_ptr < BUF_DEPTH) model[model_ptr] = d;
        else cap_done = 1'b1;
        model_ptr += (model_ptr < BUF_DEPTH) ? 1 : 0;
      end
    end
    @(posedge aclk);
    pkt_valid <= 1'b0;
    pkt_last <= 1'b0;
  endtask

  // Runaway guard sized from the table
  always @(posedge aclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: DUT did not finish the tests within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    {awvalid, wvalid, arvalid, pkt_valid, pkt_last, exp_gt, host_chk} = '0;
    {awaddr, araddr, wdata, wstrb, pkt_data, exp_data} = '0;
    bready = 1'b0;
    rready = 1'b0;
    aresetn = 1'b0;
    {test_id, cycles, model_ptr, cap_on, cap_done, buf_addr} = '0;
    limit = 1000;

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    for (int i = 0; i <= BUF_ADDR; i++) add(K_RD, i, 0, 0, 0, 0, 0);
    add(K_HOST, 0, 0, 0, 0, 0, 0);
    add(K_WR, FILTER, 64'h1111_2222_3333_4444, 8'hFF, 0, 0, 0);
    add(K_WR, FILTER, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F, 0, 0, 0);
    add(K_RD, FILTER, 0, 0, 0, 0, 64'h1111_2222_CCCC_DDDD);
    add(K_WR, VADDR, 64'hFFFF_1234_5678_9ABC, 8'hFF, 0, 0, 0);
    add(K_WR, VADDR, 64'h0000_0000_0000_EEEE, 8'h03, 0, 0, 0);
    add(K_RD, VADDR, 0, 0, 0, 0, 64'h0000_1234_5678_EEEE);
    add(K_WR, LEN, '1, 8'h0F, 0, 0, 0);
    add(K_RD, LEN, 0, 0, 0, 0, 64'h0FFF_FFFF);
    add(K_WR, PID, '1, 8'h01, 0, 0, 0);
    add(K_RD, PID, 0, 0, 0, 0, 64'h3F);
    add(K_WR, DEST, '1, 8'h01, 0, 0, 0);
    add(K_RD, DEST, 0, 0, 0, 0, 64'hF);
    add(K_WR, CTRL_1, 64'h3, 8'h01, 0, 0, 0);
    add(K_RD, CTRL_1, 0, 0, 0, 0, 64'h1);
    add(K_HOST, 0, 0, 0, 0, 0, {41'd0, 1'b1, 48'h1234_5678_EEEE, 28'hFFF_FFFF, 6'h3F, 4'hF});
    for (int i = STATE; i <= TIMER; i++) begin
      add(K_WR, i, '1, 8'hFF, 0, 0, 0);
      add(K_RD, i, 0, 0, 0, 0, 0);
    end
    // Match low byte A5 under mask FF
    add(K_WR, FILTER, 64'h0000_00A5_0000_00FF, 8'hFF, 0, 0, 0);
    add(K_WR, CTRL_0, 64'h1, 8'hFF, 0, 0, 0);
    add(K_PKT, 0, 0, 0, 3, 1, 0);
    add(K_PKT, 0, 0, 0, 2, 0, 0);
    add(K_RD, SIZE, 0, 0, 0, 0, 24);
    add(K_RD, STATE, 0, 0, 0, 0, ARMED);
    for (int i = 0; i < 3; i++) begin
      add(K_WR, BUF_ADDR, i, 8'hFF, 0, 0, 0);
      add(K_RD_BUF, BUF_DATA, 0, 0, 0, 0, 0);
    end
    add(K_WR, BUF_ADDR, 1, 8'hFF, 0, 0, 0);
    add(K_RD_BUF_PKT, BUF_DATA, 0, 0, 6, 1, 0);
    for (int i = 0; i < 16; i++) add(K_PKT, 0, 0, 0, 16, 1, 0);
    add(K_RD, STATE, 0, 0, 0, 0, DONE);
    add(K_RD, SIZE, 0, 0, 0, 0, 2048);
    add(K_PKT, 0, 0, 0, 4, 1, 0);
    add(K_RD, SIZE, 0, 0, 0, 0, 2048);
    add(K_RD, STATE, 0, 0, 0, 0, DONE);
    add(K_WR, BUF_ADDR, 255, 8'hFF, 0, 0, 0);
    add(K_RD_BUF, BUF_DATA, 0, 0, 0, 0, 0);
    add(K_WR, CTRL_0, 64'h0, 8'hFF, 0, 0, 0);
    add(K_RD, STATE, 0, 0, 0, 0, IDLE);
    add(K_WR, CTRL_0, 64'h1, 8'hFF, 0, 0, 0);
    add(K_RD, SIZE, 0, 0, 0, 0, 0);
    add(K_RD, STATE, 0, 0, 0, 0, ARMED);
    add(K_RD_GT, TIMER, 0, 0, 0, 0, 0);
    add(K_RD_GT, TIMER, 0, 0, 0, 0, 0);
    limit = table_q.size() * 40 + BUF_DEPTH * 2;

    repeat (10) @(posedge aclk);
    aresetn <= 1'b1;

    foreach (table_q[n]) begin
      case (table_q[n].kind)
        K_WR: begin
          axi_write(n, table_q[n].idx, table_q[n].data, table_q[n].strb);
          if (table_q[n].idx == BUF_ADDR) buf_addr = table_q[n].data[7:0];
          if (table_q[n].idx == CTRL_0) begin
            cap_on = table_q[n].data[0];
            if (cap_on) {model_ptr, cap_done} = '0;
          end
        end
        K_RD:    axi_read(n, table_q[n].idx, table_q[n].exp, 1'b0);
        K_RD_GT: axi_read(n, table_q[n].idx, 0, 1'b1);
        K_RD_BUF: axi_read(n, BUF_DATA, {64'd0, model[buf_addr]}, 1'b0);
        K_RD_BUF_PKT: begin
          fork
            send_packet(table_q[n].beats, table_q[n].match);
            begin
              repeat (2) @(posedge aclk);
              axi_read(n, BUF_DATA, {64'd0, model[buf_addr]}, 1'b0);
            end
          join
        end
        K_PKT: send_packet(table_q[n].beats, table_q[n].match);
        K_HOST: begin
          @(posedge aclk);
          exp_data <= table_q[n].exp;
          test_id <= n;
          host_chk <= 1'b1;
          @(posedge aclk);
          host_chk <= 1'b0;
        end
        default: ;
      endcase
    end

    repeat (4) @(posedge aclk);
    $display("Checks finished: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && n_pass > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/sniffer_ctrl_checker.sv
// Concurrent assertions on the register slave's AXI4-Lite handshake
`timescale 1ns/1ps

module sniffer_ctrl_checker (
  input logic                                   aclk,
  input logic                                   aresetn,
  input logic                                   awvalid,
  input logic                                   wvalid,
  input logic                                   awready,
  input logic                                   wready,
  input logic                                   bvalid,
  input logic                                   bready,
  input logic                                   rvalid,
  input logic                                   rready,
  input logic [sniffer_pkg::AXIL_DATA_BITS-1:0] rdata
);

  // Both channels accepted together in a one-cycle pulse after both valids
  aw_w_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    awready |-> (wready && $past(awvalid && wvalid)) ##1 (!awready && !wready))
    else $error("awready and wready not a joint one-cycle pulse");

  r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response dropped or changed before rready");

  b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

endmodule

//--- testbench/sniffer_monitor.sv
// Check module for AXI read data, AXI responses and host descriptor outputs
`timescale 1ns/1ps

module sniffer_monitor (
  input  logic                                   aclk,
  input  logic                                   bvalid,
  input  logic                                   bready,
  input  logic [1:0]                             bresp,
  input  logic                                   rvalid,
  input  logic                                   rready,
  input  logic [sniffer_pkg::AXIL_DATA_BITS-1:0] rdata,
  input  logic [1:0]                             rresp,
  input  logic                                   host_valid,
  input  logic [sniffer_pkg::VADDR_BITS-1:0]     host_vaddr,
  input  logic [sniffer_pkg::LEN_BITS-1:0]       host_len,
  input  logic [sniffer_pkg::PID_BITS-1:0]       host_pid,
  input  logic [sniffer_pkg::DEST_BITS-1:0]      host_dest,
  // Expected value for the next read or host check
  input  logic [127:0]                           exp_data,
  input  logic                                   exp_gt,
  input  logic                                   host_chk,
  input  int                                     test_id,
  output int                                     n_pass,
  output int                                     n_fail
);

  import sniffer_pkg::*;

  logic [63:0] last_rdata;
  logic [127:0] host_word;

  assign host_word = {41'd0, host_valid, host_vaddr, host_len, host_pid, host_dest};

  initial begin
    n_pass = 0;
    n_fail = 0;
    last_rdata = '0;
  end

  task automatic report(input bit ok, input logic [127:0] got, input logic [127:0] want,
                        input string what);
    if (ok) begin
      n_pass++;
      $display("[PASS] test %0d: %s", test_id, what);
    end else begin
      n_fail++;
      $display("[FAIL] %0t: test %0d %s got %h expected %h", $time, test_id, what, got,
               want);
    end
  endtask

  // Compare on the read handshake; exp_gt asks for a value above the last read
  always @(posedge aclk) begin
    if (rvalid && rready) begin
      if (exp_gt) begin
        report(rdata > last_rdata && rresp === 2'b00, {62'd0, rresp, rdata},
               {64'd0, last_rdata}, "read above previous");
      end else begin
        report(rdata === exp_data[63:0] && rresp === 2'b00, {62'd0, rresp, rdata},
               {64'd0, exp_data[63:0]}, "read");
      end
      last_rdata <= rdata;
    end
    // Write responses are always OKAY
    if (bvalid && bready) begin
      report(bresp === 2'b00, {126'd0, bresp}, '0, "write response");
    end
    if (host_chk) begin
      report(host_word === exp_data, host_word, exp_data, "host outputs");
    end
  end

endmodule
